/* logic/rvDecodePkg.sv */
// shared types for the rv32i decode slice
// holds the instruction field types, the immediate format and alu enums,
// the opcode constants and the decoded record that leaves the emitter
// every rtl file pulls this in with a wildcard import in its header
package rvDecodePkg;

    // raw instruction word as it arrives on the slave port
    typedef logic [31:0] instrT;

    // opcode field, instr[6:0]
    typedef logic [6:0] opcodeT;

    // funct3 field, instr[14:12]
    typedef logic [2:0] funct3T;

    // register index for rd, rs1, rs2
    typedef logic [4:0] regIdxT;

    // immediate after sign extension
    typedef logic [31:0] immT;

    // immediate format
    // codes 0..4 match the older control encoding, 7 marks no immediate
    typedef enum logic [2:0] {
        immI    = 3'd0,
        immS    = 3'd1,
        immB    = 3'd2,
        immJ    = 3'd3,
        immU    = 3'd4,
        immNone = 3'd7
    } immSrcT;

    // alu operation requested by the decoded word
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra
    } aluOpT;

    // rv32i base opcodes
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;
    // addi, slti, sltiu, xori, ori, andi, slli, srli, srai
    localparam opcodeT opImm    = 7'b0010011;
    // r-type register/register ops
    localparam opcodeT opReg    = 7'b0110011;

    // decoded record, msb first
    typedef struct packed {
        immT    imm;
        immSrcT immSrc;
        aluOpT  aluOp;
        // second alu operand comes from imm when set
        logic   aluSrc;
        regIdxT rd;
        regIdxT rs1;
        regIdxT rs2;
        // opcode not in the rv32i base list
        logic   illegal;
    } decodedInstrT;

endpackage

/* logic/instrIntake.sv */
// wishbone classic write-only slave for instruction words
// one-entry buffer; a write is acked one cycle after the request when
// the buffer is free, and the word is stored on that same edge
// the decode side sees instr/instrValid and frees the entry with instrTake
// reads are acked and dropped
`timescale 1ns/1ps

module instrIntake import rvDecodePkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  wbCyc,
    input  logic  wbStb,
    input  logic  wbWe,
    input  instrT wbDat,
    output logic  wbAck,
    output instrT instr,
    output logic  instrValid,
    input  logic  instrTake
);

    // buffer holds a word not yet taken
    logic full;
    // entry is free now or gets freed on this edge
    logic freeNow;
    // request to ack on the next edge
    logic accept;

    // take has priority so a new word can land while the old one leaves
    assign freeNow = ~full | instrTake;

    // no ack in the ack cycle itself, keeps ack to one cycle per transfer
    // reads need no room in the buffer
    assign accept = wbCyc & wbStb & ~wbAck & (~wbWe | freeNow);

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            wbAck <= 1'b0;
            full  <= 1'b0;
        end
        else
        begin
            wbAck <= accept;
            if (accept && wbWe)
                full <= 1'b1;
            else if (instrTake)
                full <= 1'b0;
        end
    end

    // word register
    always_ff @(posedge clk)
    begin
        if (accept && wbWe)
            instr <= wbDat;
    end

    assign instrValid = full;

endmodule

/* logic/immSrcDec.sv */
// immediate format decoder
// maps the opcode to the immediate format used by immExtend
// r-type has no immediate but is legal; anything outside the base
// opcode list gives immNone with illegal raised
`timescale 1ns/1ps

module immSrcDec import rvDecodePkg::*; (
    input  opcodeT opcode,
    output immSrcT immSrc,
    output logic   illegal
);

    always_comb
    begin
        illegal = 1'b0;
        case (opcode)
            // upper immediates
            opLui,
            opAuipc:
                immSrc = immU;
            // jump, 21-bit offset
            opJal:
                immSrc = immJ;
            // jalr, loads, alu immediates share the 12-bit i form
            opJalr,
            opLoad,
            opImm:
                immSrc = immI;
            // conditional branches
            opBranch:
                immSrc = immB;
            // sb, sh, sw
            opStore:
                immSrc = immS;
            // register ops, nothing to extend
            opReg:
                immSrc = immNone;
            default:
            begin
                immSrc  = immNone;
                illegal = 1'b1;
            end
        endcase
    end

endmodule

/* logic/immExtend.sv */
// immediate generator
// gathers the scattered immediate bits of the selected format and
// sign-extends them from instr[31]
// u places bits 31:12 over zero low bits, immNone yields zero
`timescale 1ns/1ps

module immExtend import rvDecodePkg::*; (
    input  instrT  instr,
    input  immSrcT immSrc,
    output immT    imm
);

    // sign bit is always instr[31] in rv32i
    logic sign;

    assign sign = instr[31];

    always_comb
    begin
        case (immSrc)
            // imm[11:0] = instr[31:20]
            immI:
                imm = {{20{sign}}, instr[31:20]};
            // imm[11:5] = instr[31:25], imm[4:0] = instr[11:7]
            immS:
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // branch offset, bit 0 always zero
            immB:
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            // jal offset, bit 0 always zero
            immJ:
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            // upper 20 bits
            immU:
                imm = {instr[31:12], 12'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

/* logic/aluDec.sv */
// alu operation decoder
// memory, jump and upper-immediate ops use add for address or link math,
// branches compare by subtract, op and op-imm pick by funct3
// funct7 bit 5 selects sub for op only and sra for both
// aluSrc is set wherever the second operand is the immediate
`timescale 1ns/1ps

module aluDec import rvDecodePkg::*; (
    input  instrT instr,
    output aluOpT aluOp,
    output logic  aluSrc
);

    opcodeT opcode;
    funct3T funct3;
    // instr[30], funct7 bit 5
    logic   funct7b5;
    // alu op chosen by funct3 for op and op-imm
    aluOpT  arithOp;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    always_comb
    begin
        case (funct3)
            // addi has no subtract form
            3'b000:  arithOp = (funct7b5 && opcode == opReg) ? aluSub : aluAdd;
            3'b001:  arithOp = aluSll;
            3'b010:  arithOp = aluSlt;
            3'b011:  arithOp = aluSltu;
            3'b100:  arithOp = aluXor;
            // srl/srli vs sra/srai
            3'b101:  arithOp = funct7b5 ? aluSra : aluSrl;
            3'b110:  arithOp = aluOr;
            default: arithOp = aluAnd;
        endcase
    end

    always_comb
    begin
        case (opcode)
            opLoad, opStore, opJal, opJalr, opLui, opAuipc:
            begin
                aluOp  = aluAdd;
                aluSrc = 1'b1;
            end
            // rs1 - rs2 for the compare
            opBranch:
            begin
                aluOp  = aluSub;
                aluSrc = 1'b0;
            end
            opImm:
            begin
                aluOp  = arithOp;
                aluSrc = 1'b1;
            end
            opReg:
            begin
                aluOp  = arithOp;
                aluSrc = 1'b0;
            end
            // illegal word, harmless defaults
            default:
            begin
                aluOp  = aluAdd;
                aluSrc = 1'b0;
            end
        endcase
    end

endmodule

/* logic/decodeEmit.sv */
// decoded record emitter
// takes the buffered word from instrIntake while idle, registers the
// decoded record and sends it as a wishbone classic master write
// cyc/stb rise the edge after the take and drop the edge after outAck
// register indices are zeroed for illegal words
`timescale 1ns/1ps

module decodeEmit import rvDecodePkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  instrT        instr,
    input  logic         instrValid,
    output logic         instrTake,
    input  immT          imm,
    input  immSrcT       immSrc,
    input  logic         illegal,
    input  aluOpT        aluOp,
    input  logic         aluSrc,
    output logic         outCyc,
    output logic         outStb,
    output logic         outWe,
    output decodedInstrT outDat,
    input  logic         outAck
);

    typedef enum logic {
        emitIdle,
        emitBusy
    } emitStateT;

    emitStateT    state;
    // record built from the decoders this cycle
    decodedInstrT record;

    // only one transfer pending at a time
    assign instrTake = instrValid && (state == emitIdle);

    always_comb
    begin
        record.imm     = imm;
        record.immSrc  = immSrc;
        record.aluOp   = aluOp;
        record.aluSrc  = aluSrc;
        record.illegal = illegal;
        // register fields sit at fixed positions in every format
        record.rd      = illegal ? '0 : instr[11:7];
        record.rs1     = illegal ? '0 : instr[19:15];
        record.rs2     = illegal ? '0 : instr[24:20];
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            state <= emitIdle;
        else if (state == emitIdle && instrTake)
            state <= emitBusy;
        else if (state == emitBusy && outAck)
            state <= emitIdle;
    end

    // payload held stable for the whole transfer
    always_ff @(posedge clk)
    begin
        if (instrTake)
            outDat <= record;
    end

    assign outCyc = (state == emitBusy);
    assign outStb = (state == emitBusy);
    // write-only master
    assign outWe  = 1'b1;

endmodule

/* logic/rvDecodeTop.sv */
// top of the rv32i decode slice
// words enter on the wishbone slave port, get decoded combinationally
// and leave as decodedInstrT records on the wishbone master port
// up to two items in flight, one in intake and one in the emitter
`timescale 1ns/1ps

module rvDecodeTop import rvDecodePkg::*; (
    input  logic         clk,
    input  logic         rstN,
    // slave port
    input  logic         wbCyc,
    input  logic         wbStb,
    input  logic         wbWe,
    input  instrT        wbDat,
    output logic         wbAck,
    // master port
    output logic         outCyc,
    output logic         outStb,
    output logic         outWe,
    output decodedInstrT outDat,
    input  logic         outAck
);

    instrT  instr;
    logic   instrValid;
    logic   instrTake;
    immSrcT immSrc;
    logic   illegal;
    immT    imm;
    aluOpT  aluOp;
    logic   aluSrc;

    instrIntake u_instrIntake (
        .clk        (clk),
        .rstN       (rstN),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbDat      (wbDat),
        .wbAck      (wbAck),
        .instr      (instr),
        .instrValid (instrValid),
        .instrTake  (instrTake)
    );

    // opcode is instr[6:0]
    immSrcDec u_immSrcDec (
        .opcode  (instr[6:0]),
        .immSrc  (immSrc),
        .illegal (illegal)
    );

    immExtend u_immExtend (
        .instr  (instr),
        .immSrc (immSrc),
        .imm    (imm)
    );

    aluDec u_aluDec (
        .instr  (instr),
        .aluOp  (aluOp),
        .aluSrc (aluSrc)
    );

    decodeEmit u_decodeEmit (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .instrTake  (instrTake),
        .imm        (imm),
        .immSrc     (immSrc),
        .illegal    (illegal),
        .aluOp      (aluOp),
        .aluSrc     (aluSrc),
        .outCyc     (outCyc),
        .outStb     (outStb),
        .outWe      (outWe),
        .outDat     (outDat),
        .outAck     (outAck)
    );

endmodule

/* tests/rvDecode_props.sv */
// wishbone protocol checks on both ports of the decode top level
// bound into rvDecodeTop, failures surface through the assertions
`timescale 1ns/1ps

module rvDecodeProps import rvDecodePkg::*; (
    input logic         clk,
    input logic         rstN,
    input logic         wbCyc,
    input logic         wbStb,
    input logic         wbAck,
    input logic         outCyc,
    input logic         outStb,
    input decodedInstrT outDat,
    input logic         outAck
);

    // slave ack only answers a live request
    ackInRequest: assert property (@(posedge clk) disable iff (!rstN)
        wbAck |-> wbCyc && wbStb)
        else $error("wbAck seen without a request");

    // single-cycle ack
    ackOneCycle: assert property (@(posedge clk) disable iff (!rstN)
        wbAck |=> !wbAck)
        else $error("wbAck high on two cycles in a row");

    stbInCycle: assert property (@(posedge clk) disable iff (!rstN)
        outStb |-> outCyc)
        else $error("outStb without outCyc");

    // payload frozen while the sink has not acked
    datStable: assert property (@(posedge clk) disable iff (!rstN)
        outStb && !outAck |=> $stable(outDat))
        else $error("outDat changed during a pending write");

    quietAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> !outCyc && !wbAck)
        else $error("bus active right after reset");

endmodule

bind rvDecodeTop rvDecodeProps u_rvDecodeProps (
    .clk    (clk),
    .rstN   (rstN),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbAck  (wbAck),
    .outCyc (outCyc),
    .outStb (outStb),
    .outDat (outDat),
    .outAck (outAck)
);

/* tests/rvDecodeTb.sv */
// testbench for the rv32i decode slice
// sends words on the wishbone slave port, acks the master port after
// random delays and checks each record against a reference decoder
`timescale 1ns/1ps

module rvDecodeTb import rvDecodePkg::*; ();

    // reset/idle read, formats, alu decode, illegal, burst
    localparam int numWords   = 1 + 18 + 32 + 8 + 50;
    localparam int cycleLimit = numWords * 8 + 200;
    localparam opcodeT opList [9] = '{opLui, opAuipc, opJal, opJalr, opLoad,
                                     opStore, opBranch, opImm, opReg};

    logic         clk;
    logic         rstN;
    logic         wbCyc, wbStb, wbWe, wbAck;
    instrT        wbDat;
    logic         outCyc, outStb, outWe, outAck;
    decodedInstrT outDat;

    decodedInstrT expected[$];
    decodedInstrT received[$];
    decodedInstrT gotRec, expRec;
    logic [31:0]  seed = 32'h710a;
    int           mismatches = 0;
    int           otherErrors = 0;
    int           errorsBefore = 0;
    int           passCount = 0;
    int           failCount = 0;
    int           cycleCount = 0;
    int           ackWait = 0;

    rvDecodeTop u_rvDecodeTop (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // value holds a bits-wide field, top bit of the field is the sign
    function automatic immT signExtend(input logic [31:0] v, input int bits);
        return $signed(v << (32 - bits)) >>> (32 - bits);
    endfunction

    function automatic aluOpT arithOpFor(input logic [2:0] f3, input logic f7b5,
                                         input logic isReg);
        case (f3)
            3'd0: return (f7b5 && isReg) ? aluSub : aluAdd;
            3'd1: return aluSll;
            3'd2: return aluSlt;
            3'd3: return aluSltu;
            3'd4: return aluXor;
            3'd5: return f7b5 ? aluSra : aluSrl;
            3'd6: return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    function automatic logic isKnownOpcode(input opcodeT op);
        foreach (opList[i])
            if (opList[i] == op)
                return 1'b1;
        return 1'b0;
    endfunction

    // expected record for one word
    function automatic decodedInstrT refDecode(input instrT w);
        decodedInstrT d;
        d.imm     = '0;
        d.immSrc  = immNone;
        d.aluOp   = aluAdd;
        d.aluSrc  = 1'b1;
        d.rd      = w[11:7];
        d.rs1     = w[19:15];
        d.rs2     = w[24:20];
        d.illegal = 1'b0;
        case (w[6:0])
            opLui, opAuipc:
            begin
                d.immSrc = immU;
                d.imm    = {w[31:12], 12'h000};
            end
            opJal:
            begin
                d.immSrc = immJ;
                d.imm = signExtend({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
            end
            opJalr, opLoad, opImm:
            begin
                d.immSrc = immI;
                d.imm    = signExtend({20'b0, w[31:20]}, 12);
                // op-imm never subtracts
                if (w[6:0] == opImm)
                    d.aluOp = arithOpFor(w[14:12], w[30], 1'b0);
            end
            opStore:
            begin
                d.immSrc = immS;
                d.imm    = signExtend({20'b0, w[31:25], w[11:7]}, 12);
            end
            opBranch:
            begin
                d.immSrc = immB;
                d.imm = signExtend({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
                d.aluOp  = aluSub;
                d.aluSrc = 1'b0;
            end
            opReg:
            begin
                d.aluOp  = arithOpFor(w[14:12], w[30], 1'b1);
                d.aluSrc = 1'b0;
            end
            default:
            begin
                d.illegal = 1'b1;
                d.aluSrc  = 1'b0;
                d.rd      = '0;
                d.rs1     = '0;
                d.rs2     = '0;
            end
        endcase
        return d;
    endfunction

    task automatic checkRecord(input decodedInstrT got, input decodedInstrT exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED outDat got %h expected %h", got, exp);
            mismatches++;
        end
    endtask

    task automatic checkImm(input immT got, input immT exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED outDat.imm got %h expected %h", got, exp);
            mismatches++;
        end
    endtask

    task automatic checkAluOp(input aluOpT got, input aluOpT exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED outDat.aluOp got %h expected %h", got, exp);
            mismatches++;
        end
    endtask

    task automatic checkImmSrc(input immSrcT got, input immSrcT exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED outDat.immSrc got %h expected %h", got, exp);
            mismatches++;
        end
    endtask

    task automatic checkWe(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED outWe got %h expected %h", got, exp);
            mismatches++;
        end
    endtask

    // pair records off in arrival order
    always @(negedge clk)
    begin
        while (received.size() != 0 && expected.size() != 0)
        begin
            gotRec = received.pop_front();
            expRec = expected.pop_front();
            checkImmSrc(gotRec.immSrc, expRec.immSrc);
            checkImm(gotRec.imm, expRec.imm);
            checkAluOp(gotRec.aluOp, expRec.aluOp);
            checkRecord(gotRec, expRec);
        end
    end

    // sink on the master port, ack after 0..3 idle cycles
    initial
    begin
        outAck = 1'b0;
        forever
        begin
            @(negedge clk);
            if (outAck)
                outAck = 1'b0;
            else if (outCyc && outStb && ackWait > 0)
                ackWait--;
            else if (outCyc && outStb)
            begin
                // every master transfer is a write
                checkWe(outWe, 1'b1);
                received.push_back(outDat);
                outAck  = 1'b1;
                ackWait = int'((lcgNext() >> 16) % 32'd4);
            end
        end
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
        begin
            $display("timeout after %0d cycles, %0d records never arrived",
                     cycleCount, expected.size());
            $display("Simulation failed");
            $finish;
        end
    end

    // one classic transfer, request held until the edge after ack
    task automatic busTransfer(input instrT w, input logic we);
        if (we)
            expected.push_back(refDecode(w));
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe  = we;
        wbDat = w;
        do
            @(negedge clk);
        while (!wbAck);
        @(negedge clk);
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    // drain, look for extra records, report the test
    task automatic finishTest(input string name);
        while (expected.size() != 0 || outCyc)
            @(negedge clk);
        repeat (4) @(negedge clk);
        if (received.size() != 0)
        begin
            $display("%0d extra record(s) arrived with none expected", received.size());
            otherErrors++;
            received.delete();
        end
        if (mismatches + otherErrors == errorsBefore)
        begin
            passCount++;
            $display("test %s: pass", name);
        end
        else
        begin
            failCount++;
            $display("test %s: fail", name);
        end
        errorsBefore = mismatches + otherErrors;
    endtask

    initial
    begin
        instrT w;
        int    idx;
        rstN  = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        wbDat = '0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;

        // idle bus must stay quiet, a read is acked but dropped
        repeat (6)
        begin
            @(negedge clk);
            if (outCyc)
            begin
                $display("master write appeared with no request");
                otherErrors++;
            end
        end
        busTransfer(lcgNext(), 1'b0);
        finishTest("reset and idle");

        // every opcode class, sign bit clear then set
        for (int pol = 0; pol < 2; pol++)
            for (int i = 0; i < 9; i++)
            begin
                w      = lcgNext();
                w[6:0] = opList[i];
                w[31]  = pol[0];
                busTransfer(w, 1'b1);
            end
        finishTest("immediate formats");

        for (int r = 0; r < 2; r++)
            for (int f3 = 0; f3 < 8; f3++)
                for (int b = 0; b < 2; b++)
                begin
                    w        = lcgNext();
                    w[6:0]   = (r == 0) ? opReg : opImm;
                    w[14:12] = f3[2:0];
                    w[30]    = b[0];
                    busTransfer(w, 1'b1);
                end
        finishTest("alu decode");

        for (int i = 0; i < 8; i++)
        begin
            w = lcgNext();
            // step off any base opcode
            while (isKnownOpcode(w[6:0]))
                w[6:0] = w[6:0] + 7'd1;
            busTransfer(w, 1'b1);
        end
        finishTest("illegal opcodes");

        for (int i = 0; i < 50; i++)
        begin
            w   = lcgNext();
            idx = int'((lcgNext() >> 16) % 32'd12);
            // mostly real opcodes, some left random
            if (idx < 9)
                w[6:0] = opList[idx];
            busTransfer(w, 1'b1);
        end
        finishTest("back-pressure and ordering");

        $display("tests passed %0d failed %0d", passCount, failCount);
        if (failCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* flist.f */
logic/rvDecodePkg.sv
logic/instrIntake.sv
logic/immSrcDec.sv
logic/immExtend.sv
logic/aluDec.sv
logic/decodeEmit.sv
logic/rvDecodeTop.sv
tests/rvDecode_props.sv
tests/rvDecodeTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the decode slice testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module rvDecodeTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation returned an error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
